// ==== source/adc_deser_macros.svh ====
`ifndef ADC_DESER_MACROS_SVH
`define ADC_DESER_MACROS_SVH

// --------------------
// ADC lane geometry
// --------------------

// Parallel data lanes from the converter
`define ADC_LANES 4

// One lane word, info on top of the sample
`define ADC_WORD_W 14

// Sample part of a word, bits 11 to 0
`define ADC_DATA_W 12

// Info part of a word, bits 13 to 12
`define ADC_INFO_W 2

// --------------------
// Framing
// --------------------

// Words per lane in one frame, as with the 1:4 DDR deserializer
`define ADC_DESER 4

// I or Q samples per frame, two lanes each
`define ADC_SAMPLES 8

`endif

// ==== source/adc_deser_pkg.sv ====
`include "adc_deser_macros.svh"

package adc_deser_pkg;

    // --------------------
    // One lane word
    // --------------------

    // Field view, info sits above the sample
    typedef struct packed {
        logic [`ADC_INFO_W-1:0] info;   // Converter status bits
        logic [`ADC_DATA_W-1:0] data;   // Sample value
    } sample_fields_t;

    // Raw bits as captured, or decoded fields
    typedef union packed {
        logic [`ADC_WORD_W-1:0] raw;
        sample_fields_t         fields;
    } sample_word_t;

    // --------------------
    // Frames
    // --------------------

    // Indexed [lane][slot], slot 0 is the earliest word
    typedef sample_word_t [`ADC_LANES-1:0][`ADC_DESER-1:0] raw_frame_t;

    // Decoded frame handed to the user side
    typedef struct packed {
        logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] data_i;
        logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] data_q;
        logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] info_i;
        logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] info_q;
        logic                                     overrange;  // Any info nonzero
    } iq_frame_t;

endpackage

// ==== source/frame_if.sv ====
`timescale 1ns/10ps

// Frame link between two stages
// A frame moves in a cycle with valid and ready both high
// Once valid is up, valid and frame hold until that transfer
interface frame_if #(
    parameter type frame_t = logic  // Payload, raw or decoded frame
);

    logic   valid;  // Source has a frame
    logic   ready;  // Sink can take it
    frame_t frame;  // Payload

    // Producing stage
    modport src (
        output valid,
        output frame,
        input  ready
    );

    // Consuming stage
    modport dst (
        input  valid,
        input  frame,
        output ready
    );

endinterface

// ==== source/lane_capture.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

// Gathers four accepted word sets into one raw frame
// Word of beat k lands in slot k of every lane
module lane_capture
(
    input  logic                                   clk_0,
    input  logic                                   rst_n,
    input  logic                                   in_valid,
    output logic                                   in_ready,
    input  logic [`ADC_LANES-1:0][`ADC_WORD_W-1:0] lane_words,
    frame_if.src                                   raw_out
);

    localparam int unsigned CNT_W = $clog2(`ADC_DESER);

    logic [CNT_W-1:0]          beat_cnt;   // Words already in the assembly
    logic                      live;       // Low for one cycle after reset
    logic                      accept;     // Word set taken this cycle
    logic                      last_beat;  // Assembly holds three words
    adc_deser_pkg::raw_frame_t assembly;   // Frame under construction
    adc_deser_pkg::raw_frame_t completed;  // Assembly plus the word on the pins

    // --------------------
    // Handshake
    // --------------------

    assign last_beat = (beat_cnt == CNT_W'(`ADC_DESER - 1));

    // Stall only when a finished frame would find the output register busy
    assign in_ready = live && !(last_beat && raw_out.valid && !raw_out.ready);
    assign accept   = in_valid && in_ready;

    // --------------------
    // Assembly
    // --------------------

    // Final slot comes straight from the lanes, saves a cycle
    always_comb
    begin
        completed = assembly;
        for (int l = 0; l < `ADC_LANES; l++)
        begin
            completed[l][`ADC_DESER-1].raw = lane_words[l];  // Seen as raw bits here
        end
    end

    // Payload only, slot chosen by the beat counter
    always_ff @(posedge clk_0)
    begin
        if (accept)
        begin
            for (int l = 0; l < `ADC_LANES; l++)
            begin
                assembly[l][beat_cnt].raw <= lane_words[l];
            end
        end
        if (accept && last_beat)
        begin
            raw_out.frame <= completed;  // Held until the decoder takes it
        end
    end

    // --------------------
    // Control
    // --------------------

    always_ff @(posedge clk_0)
    begin
        if (!rst_n)
        begin
            beat_cnt      <= '0;
            live          <= 1'b0;
            raw_out.valid <= 1'b0;
        end
        else
        begin
            live <= 1'b1;
            if (accept)
            begin
                beat_cnt <= beat_cnt + CNT_W'(1);  // Wraps after the fourth word
            end
            // New frame wins, otherwise drop valid once taken
            if (accept && last_beat)
            begin
                raw_out.valid <= 1'b1;
            end
            else if (raw_out.ready)
            begin
                raw_out.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/frame_decode.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

// Splits each lane word into sample and info
// Lanes 0 and 1 feed I, lanes 2 and 3 feed Q
// Single register stage, one cycle of latency
module frame_decode
(
    input  logic clk_0,
    input  logic rst_n,
    frame_if.dst raw_in,
    frame_if.src iq_out
);

    localparam int unsigned HALF_LANES = `ADC_LANES / 2;  // Lanes per I or Q

    adc_deser_pkg::iq_frame_t decoded;  // Combinational view of the incoming frame
    logic                     take;     // Raw frame moves in this cycle

    // --------------------
    // Field split
    // --------------------

    // Lane L slot t goes to sample 4*(L mod 2)+t
    always_comb
    begin
        decoded = iq_out.frame;
        for (int l = 0; l < `ADC_LANES; l++)
        begin
            for (int t = 0; t < `ADC_DESER; t++)
            begin
                if (l < HALF_LANES)
                begin
                    decoded.data_i[`ADC_DESER*(l%2)+t] = raw_in.frame[l][t].fields.data;
                    decoded.info_i[`ADC_DESER*(l%2)+t] = raw_in.frame[l][t].fields.info;
                end
                else
                begin
                    decoded.data_q[`ADC_DESER*(l%2)+t] = raw_in.frame[l][t].fields.data;
                    decoded.info_q[`ADC_DESER*(l%2)+t] = raw_in.frame[l][t].fields.info;
                end
            end
        end
        // Flag the frame if any of the 16 info fields is set
        decoded.overrange = |{decoded.info_i, decoded.info_q};
    end

    // --------------------
    // Pipeline register
    // --------------------

    // Free when empty or emptied this cycle
    assign raw_in.ready = !iq_out.valid || iq_out.ready;
    assign take         = raw_in.valid && raw_in.ready;

    always_ff @(posedge clk_0)
    begin
        if (take)
        begin
            iq_out.frame <= decoded;
        end
    end

    always_ff @(posedge clk_0)
    begin
        if (!rst_n)
        begin
            iq_out.valid <= 1'b0;
        end
        else if (take)
        begin
            iq_out.valid <= 1'b1;
        end
        else if (iq_out.ready)
        begin
            iq_out.valid <= 1'b0;  // Taken, nothing behind it
        end
    end

endmodule

// ==== source/frame_output.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

// Two-entry frame buffer in front of the user ports
// Head entry is always on the outputs
module frame_output
(
    input  logic                                     clk_0,
    input  logic                                     rst_n,
    frame_if.dst                                     iq_in,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_i,
    output logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_q,
    output logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_i,
    output logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_q,
    output logic                                     out_overrange
);

    localparam int unsigned BUF_DEPTH = 2;
    localparam int unsigned CNT_W     = $clog2(BUF_DEPTH + 1);

    adc_deser_pkg::iq_frame_t buf_mem [BUF_DEPTH];  // Frame storage
    logic                     wr_ptr;               // Next free entry
    logic                     rd_ptr;               // Head entry
    logic [CNT_W-1:0]         count;                // Entries in use
    logic [CNT_W-1:0]         count_next;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en = iq_in.valid && iq_in.ready;
    assign rd_en = out_valid && out_ready;

    always_comb
    begin
        count_next = count;
        if (wr_en && !rd_en)
        begin
            count_next = count + CNT_W'(1);
        end
        else if (!wr_en && rd_en)
        begin
            count_next = count - CNT_W'(1);
        end
    end

    // --------------------
    // Storage
    // --------------------

    always_ff @(posedge clk_0)
    begin
        if (wr_en)
        begin
            buf_mem[wr_ptr] <= iq_in.frame;
        end
    end

    always_ff @(posedge clk_0)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= 1'b0;
            rd_ptr      <= 1'b0;
            count       <= '0;
            iq_in.ready <= 1'b1;  // Empty buffer
        end
        else
        begin
            if (wr_en) wr_ptr <= !wr_ptr;
            if (rd_en) rd_ptr <= !rd_ptr;
            count       <= count_next;
            iq_in.ready <= (count_next != CNT_W'(BUF_DEPTH));  // Registered, low when full
        end
    end

    // --------------------
    // User side
    // --------------------

    assign out_valid     = (count != '0);
    assign out_data_i    = buf_mem[rd_ptr].data_i;
    assign out_data_q    = buf_mem[rd_ptr].data_q;
    assign out_info_i    = buf_mem[rd_ptr].info_i;
    assign out_info_q    = buf_mem[rd_ptr].info_q;
    assign out_overrange = buf_mem[rd_ptr].overrange;

endmodule

// ==== source/adc_deser_top.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

// Sample capture path of the four-lane ADC
// Capture, decode and output buffer in a row
module adc_deser_top
(
    input  logic                                     clk_0,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic [`ADC_LANES-1:0][`ADC_WORD_W-1:0]   lane_words,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_i,
    output logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_q,
    output logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_i,
    output logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_q,
    output logic                                     out_overrange
);

    // --------------------
    // Stage links
    // --------------------

    frame_if #(.frame_t(adc_deser_pkg::raw_frame_t)) raw_if ();  // Capture to decode
    frame_if #(.frame_t(adc_deser_pkg::iq_frame_t))  iq_if ();   // Decode to buffer

    lane_capture lane_capture_i (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_words (lane_words),
        .raw_out    (raw_if.src)
    );

    frame_decode frame_decode_i (
        .clk_0  (clk_0),
        .rst_n  (rst_n),
        .raw_in (raw_if.dst),
        .iq_out (iq_if.src)
    );

    frame_output frame_output_i (
        .clk_0         (clk_0),
        .rst_n         (rst_n),
        .iq_in         (iq_if.dst),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data_i    (out_data_i),
        .out_data_q    (out_data_q),
        .out_info_i    (out_info_i),
        .out_info_q    (out_info_q),
        .out_overrange (out_overrange)
    );

endmodule

// ==== sim/adc_deser_properties.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

// Protocol checks on the user side of adc_deser_top
module adc_deser_properties
(
    input logic                                     clk_0,
    input logic                                     rst_n,
    input logic                                     in_ready,
    input logic                                     out_valid,
    input logic                                     out_ready,
    input logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_i,
    input logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_q,
    input logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_i,
    input logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_q,
    input logic                                     out_overrange
);

    int fail_cnt = 0;  // Failed property count, summed into the end-of-run line

    // --------------------
    // Properties
    // --------------------

    // Both handshakes still quiet in the first cycle out of reset
    property reset_exit_p;
        @(posedge clk_0) $rose(rst_n) |-> (!out_valid && !in_ready);
    endproperty

    // A stalled frame stays put until it is taken
    property held_output_p;
        @(posedge clk_0) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data_i) && $stable(out_data_q)
            && $stable(out_info_i) && $stable(out_info_q) && $stable(out_overrange));
    endproperty

    // Flag must agree with the info fields it summarises
    property overrange_p;
        @(posedge clk_0) disable iff (!rst_n)
        out_valid |-> (out_overrange == (|{out_info_i, out_info_q}));
    endproperty

    reset_exit_a : assert property (reset_exit_p)
    else
    begin
        fail_cnt++;
        $error("out_valid or in_ready high in the first cycle after reset");
    end

    held_output_a : assert property (held_output_p)
    else
    begin
        fail_cnt++;
        $error("stalled output frame changed or dropped its valid");
    end

    overrange_a : assert property (overrange_p)
    else
    begin
        fail_cnt++;
        $error("out_overrange disagrees with the info fields");
    end

endmodule

// ==== sim/adc_deser_tb.sv ====
`timescale 1ns/10ps
`include "adc_deser_macros.svh"

module adc_deser_tb;

    localparam int          N_PLAIN   = 12;                   // Back to back, no stalls
    localparam int          N_GAPS    = 12;                   // Random in_valid gaps
    localparam int          N_BP      = 24;                   // Random out_ready stalls
    localparam int          N_FRAMES  = N_PLAIN + N_GAPS + N_BP;
    localparam int          WATCHDOG  = 40 * N_FRAMES + 100;  // In clock cycles
    localparam int          DRIVE_DLY = 1;                    // ns after the rising edge
    localparam logic [31:0] SEED      = 32'h513b83d5;
    localparam logic [31:0] LCG_MUL   = 32'd1664525;
    localparam logic [31:0] LCG_INC   = 32'd1013904223;

    typedef logic [`ADC_LANES-1:0][`ADC_WORD_W-1:0] word_set_t;  // One word per lane

    logic                                     clk_0 = 1'b0;
    logic                                     rst_n;
    logic                                     in_valid;
    logic                                     in_ready;
    word_set_t                                lane_words;
    logic                                     out_valid;
    logic                                     out_ready;
    logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_i;
    logic [`ADC_SAMPLES-1:0][`ADC_DATA_W-1:0] out_data_q;
    logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_i;
    logic [`ADC_SAMPLES-1:0][`ADC_INFO_W-1:0] out_info_q;
    logic                                     out_overrange;

    logic [31:0]              rng_state = SEED;
    adc_deser_pkg::iq_frame_t exp_q[$];           // Expected frames, oldest first
    word_set_t                beats[`ADC_DESER];  // Accepted sets of the frame in progress
    int                       beat_idx = 0;
    int                       cycle = 0;
    int                       frames_out = 0;
    int                       first_acc = -1;     // Cycle of the first fourth acceptance
    int                       hold_left = 0;      // Cycles left in the current out_ready level
    int                       value_errs = 0;
    int                       other_errs = 0;
    int                       ovr_hi = 0;
    int                       ovr_lo = 0;
    bit                       beat_taken;
    bit                       bp_on = 1'b0;
    bit                       first_out_seen = 1'b0;
    bit                       ready_low_seen = 1'b0;

    always #2 clk_0 = ~clk_0;  // 4 ns period

    adc_deser_top adc_deser_top_i (.*);

    bind adc_deser_top adc_deser_properties adc_deser_properties_i (
        .clk_0         (clk_0),
        .rst_n         (rst_n),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data_i    (out_data_i),
        .out_data_q    (out_data_q),
        .out_info_i    (out_info_i),
        .out_info_q    (out_info_q),
        .out_overrange (out_overrange)
    );

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [15:0] next_rand();
        rng_state = rng_state * LCG_MUL + LCG_INC;
        return rng_state[31:16];  // Upper half, low bits of an LCG are weak
    endfunction

    task automatic check_bits(input string name, input logic [95:0] exp, input logic [95:0] got);
        assert (got === exp)
        else
        begin
            value_errs++;
            $display("ERR %s exp %0h got %0h", name, exp, got);
        end
    endtask

    // Long stalls, short bursts, so the whole pipe backs up
    task automatic drive_out_ready();
        logic [15:0] r;
        if (!bp_on)
        begin
            out_ready = 1'b1;
        end
        else if (hold_left > 0)
        begin
            hold_left--;
        end
        else
        begin
            r         = next_rand();
            out_ready = !out_ready;
            hold_left = out_ready ? int'(r % 6) : 8 + int'(r % 32);
        end
    endtask

    // One clock, handshake seen at mid-cycle like the DUT sees it at the edge
    task automatic step();
        @(negedge clk_0);
        beat_taken = in_valid && in_ready;
        @(posedge clk_0);
        #DRIVE_DLY;
        drive_out_ready();
    endtask

    task automatic send_word_set(input word_set_t w, input int max_gap);
        int          gap;
        logic [15:0] junk;
        gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
        repeat (gap)
        begin
            junk       = next_rand();
            in_valid   = 1'b0;
            lane_words = {`ADC_LANES{junk[`ADC_WORD_W-1:0]}};  // Junk that must be ignored
            step();
        end
        in_valid   = 1'b1;
        lane_words = w;
        do
            step();
        while (!beat_taken);
    endtask

    // Mode 0/1 all info zero, 2 a single nonzero info, 3 fully random
    task automatic send_frame(input int max_gap);
        logic [`ADC_DESER-1:0][`ADC_LANES-1:0][`ADC_WORD_W-1:0] fw;  // [beat][lane]
        logic [15:0]                                            r;
        logic [1:0]                                             mode;
        r    = next_rand();
        mode = r[1:0];
        for (int t = 0; t < `ADC_DESER; t++)
        begin
            for (int l = 0; l < `ADC_LANES; l++)
            begin
                r        = next_rand();
                fw[t][l] = r[`ADC_WORD_W-1:0];
                if (mode != 2'd3)
                    fw[t][l][`ADC_WORD_W-1:`ADC_DATA_W] = '0;
            end
        end
        if (mode == 2'd2)
        begin
            r = next_rand();
            fw[r[3:2]][r[1:0]][`ADC_WORD_W-1:`ADC_DATA_W] = (r[5:4] == 2'd0) ? 2'd1 : r[5:4];
        end
        for (int t = 0; t < `ADC_DESER; t++)
            send_word_set(fw[t], max_gap);
    endtask

    task automatic check_reset_outputs();
        check_bits("out_valid", 1'b0, out_valid);
        check_bits("in_ready", 1'b0, in_ready);
    endtask

    // --------------------
    // Reference model
    // --------------------

    // Lane L beat t goes to sample 4*(L mod 2)+t, lanes 0/1 are I
    task automatic capture_beat();
        adc_deser_pkg::iq_frame_t exp;
        logic [`ADC_WORD_W-1:0]   w;
        int                       s;
        beats[beat_idx] = lane_words;
        beat_idx++;
        if (beat_idx == `ADC_DESER)
        begin
            exp = '0;
            for (int l = 0; l < `ADC_LANES; l++)
            begin
                for (int t = 0; t < `ADC_DESER; t++)
                begin
                    w = beats[t][l];
                    s = 4 * (l % 2) + t;
                    if (l < 2)
                    begin
                        exp.data_i[s] = w[`ADC_DATA_W-1:0];
                        exp.info_i[s] = w[`ADC_WORD_W-1:`ADC_DATA_W];
                    end
                    else
                    begin
                        exp.data_q[s] = w[`ADC_DATA_W-1:0];
                        exp.info_q[s] = w[`ADC_WORD_W-1:`ADC_DATA_W];
                    end
                    exp.overrange |= (w[`ADC_WORD_W-1:`ADC_DATA_W] != '0);
                end
            end
            exp_q.push_back(exp);
            beat_idx = 0;
            if (first_acc < 0)
                first_acc = cycle;  // Cycle of the first frame's fourth acceptance
        end
    endtask

    task automatic check_output_frame();
        adc_deser_pkg::iq_frame_t exp;
        frames_out++;
        assert (exp_q.size() > 0)
        else
        begin
            other_errs++;
            $display("Output frame %0d appeared with no frame expected", frames_out);
        end
        if (exp_q.size() > 0)
        begin
            exp = exp_q.pop_front();
            check_bits("out_data_i", exp.data_i, out_data_i);
            check_bits("out_data_q", exp.data_q, out_data_q);
            check_bits("out_info_i", exp.info_i, out_info_i);
            check_bits("out_info_q", exp.info_q, out_info_q);
            check_bits("out_overrange", exp.overrange, out_overrange);
            if (exp.overrange)
                ovr_hi++;
            else
                ovr_lo++;
        end
    endtask

    // Mid-cycle sampling, everything driven after the edge has settled
    always @(negedge clk_0)
    begin
        cycle++;
        if (rst_n)
        begin
            if (bp_on && !in_ready)
                ready_low_seen = 1'b1;
            if (in_valid && in_ready)
                capture_beat();
            if (out_valid && !first_out_seen)
            begin
                first_out_seen = 1'b1;
                assert (first_acc >= 0 && cycle - first_acc == 3)
                else
                begin
                    other_errs++;
                    $display("First frame appeared %0d cycles after its last word, not 3",
                             cycle - first_acc);
                end
            end
            if (out_valid && out_ready)
                check_output_frame();
        end
    end

    // --------------------
    // Run control
    // --------------------

    task automatic report_and_finish();
        int prop_errs;
        prop_errs = adc_deser_top_i.adc_deser_properties_i.fail_cnt;
        $display("Errors: value %0d, other %0d, property %0d", value_errs, other_errs, prop_errs);
        if (value_errs + other_errs + prop_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    initial
    begin
        repeat (WATCHDOG) @(posedge clk_0);
        other_errs++;
        $display("Timeout after %0d cycles with %0d of %0d frames out", WATCHDOG, frames_out,
                 N_FRAMES);
        report_and_finish();
    end

    initial
    begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        lane_words = '0;
        repeat (3)
        begin
            @(posedge clk_0);
            @(negedge clk_0);
            check_reset_outputs();
        end
        @(posedge clk_0);  // Fourth reset edge
        #DRIVE_DLY;
        rst_n     = 1'b1;
        out_ready = 1'b1;
        @(negedge clk_0);
        check_reset_outputs();  // First cycle out of reset
        @(posedge clk_0);
        #DRIVE_DLY;
        repeat (N_PLAIN) send_frame(0);
        repeat (N_GAPS) send_frame(3);
        bp_on = 1'b1;
        repeat (N_BP) send_frame(0);
        in_valid = 1'b0;
        bp_on    = 1'b0;
        while (frames_out < N_FRAMES)
            step();
        repeat (8) step();  // Nothing extra may follow
        assert (exp_q.size() == 0 && frames_out == N_FRAMES)
        else
        begin
            other_errs++;
            $display("Frame count wrong, %0d out, %0d still expected", frames_out, exp_q.size());
        end
        assert (ready_low_seen)
        else
        begin
            other_errs++;
            $display("in_ready never dropped while out_ready stalled");
        end
        assert (ovr_hi > 0 && ovr_lo > 0)
        else
        begin
            other_errs++;
            $display("Overrange flag not seen both high and low");
        end
        report_and_finish();
    end

endmodule

// ==== compile.f ====
+incdir+source
source/adc_deser_pkg.sv
source/frame_if.sv
source/lane_capture.sv
source/frame_decode.sv
source/frame_output.sv
source/adc_deser_top.sv
sim/adc_deser_properties.sv
sim/adc_deser_tb.sv
